// File: mcu_pkg.sv
package mcu_pkg;

  // One memory word, also one stream beat
  typedef logic [15:0] data_t;

  // Data memory address, 256 words deep
  typedef logic [7:0] mem_addr_t;

  // Loop count for address, inter and intra iterations
  typedef logic [15:0] count_t;

  // Register select on the host write port
  typedef logic [1:0] cfg_sel_t;

  localparam cfg_sel_t CFG_SEL_ADDR  = 2'd0;
  localparam cfg_sel_t CFG_SEL_INTER = 2'd1;
  localparam cfg_sel_t CFG_SEL_INTRA = 2'd2;
  // Any write here is a start command
  localparam cfg_sel_t CFG_SEL_CTRL  = 2'd3;

  // Run-level state, shared by global FSM and reader
  typedef enum logic [1:0] {
    GLO_IDLE,
    GLO_RUN,
    GLO_DONE,
    GLO_ERR
  } glo_state_t;

  // Reader state
  typedef enum logic [1:0] {
    LOC_IDLE,
    LOC_RUN,
    LOC_END,
    LOC_ERR
  } loc_state_t;

endpackage

// File: mcu_config_regs.sv
module mcu_config_regs
  import mcu_pkg::*;
(
  input  logic       clk,
  input  logic       rst,

  // Host register write port
  input  logic       cfg_write,
  input  cfg_sel_t   cfg_sel,
  input  count_t     cfg_wdata,

  input  glo_state_t glo_state,

  output count_t     addr_count,
  output count_t     inter_count,
  output count_t     intra_count,
  output logic       start,

  // Status
  output logic       busy,
  output logic       done,
  output logic       error
);

  logic running;

  assign running = (glo_state == GLO_RUN);

  // Writes are dropped during a run so the reader sees stable counts
  always_ff @(posedge clk) begin
    if (rst) begin
      addr_count  <= '0;
      inter_count <= '0;
      intra_count <= '0;
      start       <= 1'b0;
    end else begin
      start <= 1'b0;
      if (cfg_write && !running) begin
        case (cfg_sel)
          CFG_SEL_ADDR:  addr_count  <= cfg_wdata;
          CFG_SEL_INTER: inter_count <= cfg_wdata;
          CFG_SEL_INTRA: intra_count <= cfg_wdata;
          CFG_SEL_CTRL:  start       <= 1'b1;
          default:       start       <= 1'b0;
        endcase
      end
    end
  end

  assign busy  = running;
  assign done  = (glo_state == GLO_DONE);
  assign error = (glo_state == GLO_ERR);

  // A second start in back-to-back cycles would land on a running FSM
  a_no_start_while_running: assert property (
    @(posedge clk) disable iff (rst)
    start |-> glo_state != GLO_RUN
  ) else $error("start pulse while global FSM is running");

endmodule

// File: mcu_global_fsm.sv
module mcu_global_fsm
  import mcu_pkg::*;
(
  input  logic       clk,
  input  logic       rst,

  input  logic       start,
  input  logic       finished,
  input  logic       fault,

  output glo_state_t glo_state
);

  always_ff @(posedge clk) begin
    if (rst) begin
      glo_state <= GLO_IDLE;
    end else begin
      case (glo_state)
        GLO_IDLE: begin
          if (start) begin
            glo_state <= GLO_RUN;
          end
        end
        GLO_RUN: begin
          // Reader reports either a clean end or a bad config
          if (fault) begin
            glo_state <= GLO_ERR;
          end else if (finished) begin
            glo_state <= GLO_DONE;
          end
        end
        GLO_DONE: begin
          if (start) begin
            glo_state <= GLO_RUN;
          end
        end
        GLO_ERR: begin
          if (start) begin
            glo_state <= GLO_RUN;
          end
        end
        default: begin
          glo_state <= GLO_IDLE;
        end
      endcase
    end
  end

  // The reader ends a run exactly one way
  a_finished_fault_excl: assert property (
    @(posedge clk) disable iff (rst)
    !(finished && fault)
  ) else $error("finished and fault asserted together");

endmodule

// File: mcu_data_bram.sv
module mcu_data_bram
  import mcu_pkg::*;
(
  input  logic      clk,
  input  logic      rst,

  // Host write port
  input  logic      mem_write,
  input  mem_addr_t mem_addr,
  input  data_t     mem_wdata,

  // Reader port
  input  logic      rd_en,
  input  mem_addr_t rd_addr,
  output data_t     rd_data,
  output logic      rd_ack
);

  data_t mem [2**$bits(mem_addr_t)];

  always_ff @(posedge clk) begin
    if (mem_write) begin
      mem[mem_addr] <= mem_wdata;
    end
    if (rd_en) begin
      rd_data <= mem[rd_addr];
    end
  end

  // Ack lines up with the registered read data
  always_ff @(posedge clk) begin
    if (rst) begin
      rd_ack <= 1'b0;
    end else begin
      rd_ack <= rd_en;
    end
  end

endmodule

// File: mcu_bram_reader.sv
module mcu_bram_reader
  import mcu_pkg::*;
#(
  parameter int CREDITS = 4
) (
  input  logic       clk,
  input  logic       rst,

  input  glo_state_t glo_state,
  input  count_t     addr_count,
  input  count_t     inter_count,
  input  count_t     intra_count,

  // Memory read port
  output logic       rd_en,
  output mem_addr_t  rd_addr,
  input  data_t      rd_data,
  input  logic       rd_ack,

  // Credit-based output stream
  output data_t      out_data,
  output logic       out_valid,
  output logic       out_last,
  input  logic       credit_return,

  output logic       finished,
  output logic       fault
);

  loc_state_t loc_state;
  count_t     addr_idx;
  count_t     inter_idx;
  count_t     intra_idx;
  data_t      word_q;
  logic       have_word;
  // Wide enough for CREDITS up to 15
  logic [3:0] credit_cnt;

  logic counts_ok;
  logic run_start;
  logic last_rep;
  logic last_addr;
  logic last_sweep;
  logic final_beat;
  logic issue;

  assign counts_ok  = (addr_count != '0) && (inter_count != '0) && (intra_count != '0);
  assign run_start  = (loc_state == LOC_IDLE) && (glo_state == GLO_RUN) && counts_ok;
  assign last_rep   = (intra_idx == intra_count - 16'd1);
  assign last_addr  = (addr_idx == addr_count - 16'd1);
  assign last_sweep = (inter_idx == inter_count - 16'd1);
  assign final_beat = last_rep && last_addr && last_sweep;
  // One beat per cycle as long as a word is held and a credit is left
  assign issue      = (loc_state == LOC_RUN) && have_word && (credit_cnt != '0);
  assign rd_addr    = mem_addr_t'(addr_idx);

  always_ff @(posedge clk) begin
    if (rst) begin
      loc_state <= LOC_IDLE;
      addr_idx  <= '0;
      inter_idx <= '0;
      intra_idx <= '0;
      have_word <= 1'b0;
      rd_en     <= 1'b0;
      out_valid <= 1'b0;
      out_last  <= 1'b0;
      finished  <= 1'b0;
      fault     <= 1'b0;
    end else begin
      rd_en     <= 1'b0;
      out_valid <= 1'b0;
      out_last  <= 1'b0;
      finished  <= 1'b0;
      fault     <= 1'b0;
      case (loc_state)
        LOC_IDLE: begin
          if (glo_state == GLO_RUN) begin
            if (counts_ok) begin
              loc_state <= LOC_RUN;
              addr_idx  <= '0;
              inter_idx <= '0;
              intra_idx <= '0;
              have_word <= 1'b0;
              rd_en     <= 1'b1;
            end else begin
              loc_state <= LOC_ERR;
              fault     <= 1'b1;
            end
          end
        end
        LOC_RUN: begin
          if (rd_ack) begin
            have_word <= 1'b1;
          end
          if (issue) begin
            out_valid <= 1'b1;
            out_last  <= final_beat;
            if (!last_rep) begin
              intra_idx <= intra_idx + 16'd1;
            end else begin
              intra_idx <= '0;
              have_word <= 1'b0;
              if (final_beat) begin
                finished  <= 1'b1;
                loc_state <= LOC_END;
              end else begin
                // Fetch next word, wrapping at the end of a sweep
                rd_en <= 1'b1;
                if (last_addr) begin
                  addr_idx  <= '0;
                  inter_idx <= inter_idx + 16'd1;
                end else begin
                  addr_idx <= addr_idx + 16'd1;
                end
              end
            end
          end
        end
        LOC_END, LOC_ERR: begin
          if (glo_state != GLO_RUN) begin
            loc_state <= LOC_IDLE;
          end
        end
        default: begin
          loc_state <= LOC_IDLE;
        end
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (rd_ack) begin
      word_q <= rd_data;
    end
    if (issue) begin
      out_data <= word_q;
    end
  end

  // Returned credit and sent beat in one cycle cancel out
  always_ff @(posedge clk) begin
    if (rst || run_start) begin
      credit_cnt <= 4'(CREDITS);
    end else begin
      credit_cnt <= credit_cnt - {3'b000, issue} + {3'b000, credit_return};
    end
  end

  a_beat_has_credit: assert property (
    @(posedge clk) disable iff (rst)
    out_valid |-> $past(credit_cnt) != '0
  ) else $error("beat sent without a credit");

  // Consumer must not return more credits than beats received
  a_credit_bound: assert property (
    @(posedge clk) disable iff (rst)
    credit_cnt <= 4'(CREDITS)
  ) else $error("credit count above CREDITS");

endmodule

// File: mcu_stream_top.sv
module mcu_stream_top #(
  parameter int CREDITS = 4
) (
  input  logic               clk,
  input  logic               rst,

  // Host register port
  input  logic               cfg_write,
  input  mcu_pkg::cfg_sel_t  cfg_sel,
  input  mcu_pkg::count_t    cfg_wdata,

  // Host memory port
  input  logic               mem_write,
  input  mcu_pkg::mem_addr_t mem_addr,
  input  mcu_pkg::data_t     mem_wdata,

  output logic               busy,
  output logic               done,
  output logic               error,

  // Output stream
  output mcu_pkg::data_t     out_data,
  output logic               out_valid,
  output logic               out_last,
  input  logic               credit_return
);

  mcu_pkg::count_t     addr_count;
  mcu_pkg::count_t     inter_count;
  mcu_pkg::count_t     intra_count;
  mcu_pkg::glo_state_t glo_state;
  mcu_pkg::mem_addr_t  rd_addr;
  mcu_pkg::data_t      rd_data;
  logic                start;
  logic                finished;
  logic                fault;
  logic                rd_en;
  logic                rd_ack;

  mcu_config_regs regs0 (
    .clk(clk), .rst(rst),
    .cfg_write(cfg_write), .cfg_sel(cfg_sel), .cfg_wdata(cfg_wdata),
    .glo_state(glo_state),
    .addr_count(addr_count), .inter_count(inter_count), .intra_count(intra_count),
    .start(start), .busy(busy), .done(done), .error(error)
  );

  mcu_global_fsm glo0 (
    .clk(clk), .rst(rst),
    .start(start), .finished(finished), .fault(fault),
    .glo_state(glo_state)
  );

  mcu_data_bram bram0 (
    .clk(clk), .rst(rst),
    .mem_write(mem_write), .mem_addr(mem_addr), .mem_wdata(mem_wdata),
    .rd_en(rd_en), .rd_addr(rd_addr), .rd_data(rd_data), .rd_ack(rd_ack)
  );

  mcu_bram_reader #(
    .CREDITS(CREDITS)
  ) reader0 (
    .clk(clk), .rst(rst),
    .glo_state(glo_state),
    .addr_count(addr_count), .inter_count(inter_count), .intra_count(intra_count),
    .rd_en(rd_en), .rd_addr(rd_addr), .rd_data(rd_data), .rd_ack(rd_ack),
    .out_data(out_data), .out_valid(out_valid), .out_last(out_last),
    .credit_return(credit_return),
    .finished(finished), .fault(fault)
  );

endmodule

// File: tb_mcu_stream_top.sv
module tb_mcu_stream_top;
  import mcu_pkg::*;

  localparam int CREDITS  = 4;
  localparam int TV_WORDS = 1024;

  logic      clk;
  logic      rst;
  logic      cfg_write;
  cfg_sel_t  cfg_sel;
  count_t    cfg_wdata;
  logic      mem_write;
  mem_addr_t mem_addr;
  data_t     mem_wdata;
  logic      busy;
  logic      done;
  logic      error;
  data_t     out_data;
  logic      out_valid;
  logic      out_last;
  logic      credit_return;

  logic [15:0] tv [TV_WORDS];
  data_t       rx_data [$];
  logic        rx_last [$];
  data_t       exp_data [$];
  int          due_q [$];
  integer      seed = 8340;
  int          max_delay;
  int          beats_seen;
  int          credits_sent;
  int          errors;
  int          passed;
  int          failed;
  int          limit_cycles;

  mcu_stream_top dut0 (
    .clk(clk), .rst(rst),
    .cfg_write(cfg_write), .cfg_sel(cfg_sel), .cfg_wdata(cfg_wdata),
    .mem_write(mem_write), .mem_addr(mem_addr), .mem_wdata(mem_wdata),
    .busy(busy), .done(done), .error(error),
    .out_data(out_data), .out_valid(out_valid), .out_last(out_last),
    .credit_return(credit_return)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  // Sum of addr * inter * intra over all tests
  function automatic int total_beats();
    int p;
    int total;
    p = 1;
    total = 0;
    for (int t = 0; t < int'(tv[0]); t++) begin
      total = total + int'(tv[p]) * int'(tv[p + 1]) * int'(tv[p + 2]);
      p = p + 4 + int'(tv[p]);
    end
    return total;
  endfunction

  task automatic write_reg(input cfg_sel_t sel, input count_t value);
    @(posedge clk);
    cfg_write <= 1'b1;
    cfg_sel   <= sel;
    cfg_wdata <= value;
    @(posedge clk);
    cfg_write <= 1'b0;
  endtask

  task automatic load_memory(input int base, input int words);
    for (int i = 0; i < words; i++) begin
      @(posedge clk);
      mem_write <= 1'b1;
      mem_addr  <= mem_addr_t'(i);
      mem_wdata <= tv[base + i];
    end
    @(posedge clk);
    mem_write <= 1'b0;
  endtask

  // Each sweep walks the addresses, each word repeated intra times
  task automatic build_expected(input int base, input int n_addr, input int n_inter,
                                input int n_intra);
    exp_data.delete();
    for (int s = 0; s < n_inter; s++) begin
      for (int a = 0; a < n_addr; a++) begin
        for (int r = 0; r < n_intra; r++) begin
          exp_data.push_back(tv[base + a]);
        end
      end
    end
  endtask

  task automatic check_stream();
    assert (rx_data.size() == exp_data.size()) else begin
      $display("Error at %0t: got %0d beats, expected %0d", $time,
               rx_data.size(), exp_data.size());
      errors = errors + 1;
    end
    for (int i = 0; i < rx_data.size() && i < exp_data.size(); i++) begin
      assert (rx_data[i] == exp_data[i]) else begin
        $display("Error at %0t: beat %0d data %h, expected %h", $time, i,
                 rx_data[i], exp_data[i]);
        errors = errors + 1;
      end
      assert (rx_last[i] == (i == exp_data.size() - 1)) else begin
        $display("Error at %0t: beat %0d last flag %b is wrong", $time, i, rx_last[i]);
        errors = errors + 1;
      end
    end
  endtask

  task automatic report_test(input int idx, input int errs_before);
    if (errors == errs_before) begin
      passed = passed + 1;
      $display("Test %0d: pass, %0d beats", idx, rx_data.size());
    end else begin
      failed = failed + 1;
      $display("Test %0d: fail, %0d errors", idx, errors - errs_before);
    end
  endtask

  // Consumer takes every beat and returns its credit after a random delay
  initial begin : consumer
    int cyc;
    int delay;
    int due;
    cyc = 0;
    credit_return = 1'b0;
    forever begin
      @(posedge clk);
      cyc = cyc + 1;
      if (out_valid) begin
        rx_data.push_back(out_data);
        rx_last.push_back(out_last);
        beats_seen = beats_seen + 1;
        assert (beats_seen - credits_sent <= CREDITS) else begin
          $display("Error at %0t: %0d beats outstanding, limit %0d", $time,
                   beats_seen - credits_sent, CREDITS);
          errors = errors + 1;
        end
        delay = $unsigned($random(seed)) % (max_delay + 1);
        due = cyc + delay;
        // One return per cycle at most
        if (due_q.size() > 0 && due <= due_q[$]) begin
          due = due_q[$] + 1;
        end
        due_q.push_back(due);
      end
      if (due_q.size() > 0 && due_q[0] <= cyc) begin
        void'(due_q.pop_front());
        credit_return <= 1'b1;
        credits_sent = credits_sent + 1;
      end else begin
        credit_return <= 1'b0;
      end
    end
  end

  initial begin : watchdog
    wait (limit_cycles > 0);
    repeat (limit_cycles) @(posedge clk);
    $display("Timeout: the run did not finish within %0d clock cycles", limit_cycles);
    $display("SOME TESTS FAILED");
    $finish;
  end

  initial begin : main
    int   p;
    int   n_tests;
    int   n_addr;
    int   n_inter;
    int   n_intra;
    int   n;
    int   errs_before;
    logic exp_err;
    rst       = 1'b1;
    cfg_write = 1'b0;
    cfg_sel   = CFG_SEL_ADDR;
    cfg_wdata = '0;
    mem_write = 1'b0;
    mem_addr  = '0;
    mem_wdata = '0;
    $readmemh("mcu_stream_tests.txt", tv);
    n_tests = int'(tv[0]);
    limit_cycles = total_beats() * 20 + 2000;
    repeat (16) @(posedge clk);
    rst <= 1'b0;
    repeat (4) @(posedge clk);

    // Idle outputs after reset
    errs_before = errors;
    assert (!busy && !done && !error && !out_valid && !out_last) else begin
      $display("Error at %0t: outputs not idle after reset", $time);
      errors = errors + 1;
    end
    assert (rx_data.size() == 0) else begin
      $display("Error at %0t: beat seen before any start", $time);
      errors = errors + 1;
    end
    report_test(0, errs_before);
    if (n_tests == 0) begin
      $display("No test vectors were read from mcu_stream_tests.txt");
      errors = errors + 1;
    end

    p = 1;
    for (int t = 1; t <= n_tests; t++) begin
      n_addr    = int'(tv[p]);
      n_inter   = int'(tv[p + 1]);
      n_intra   = int'(tv[p + 2]);
      max_delay = int'(tv[p + 3]);
      exp_err   = (n_addr == 0) || (n_inter == 0) || (n_intra == 0);
      errs_before = errors;
      rx_data.delete();
      rx_last.delete();
      build_expected(p + 4, n_addr, n_inter, n_intra);
      load_memory(p + 4, n_addr);
      write_reg(CFG_SEL_ADDR, tv[p]);
      write_reg(CFG_SEL_INTER, tv[p + 1]);
      write_reg(CFG_SEL_INTRA, tv[p + 2]);
      write_reg(CFG_SEL_CTRL, '0);
      if (exp_err) begin
        n = 0;
        while (!error && n < 8) begin
          @(posedge clk);
          n = n + 1;
        end
        assert (error && n <= 4) else begin
          $display("Error at %0t: error flag not raised within 4 cycles of start", $time);
          errors = errors + 1;
        end
        repeat (8) @(posedge clk);
        assert (!done && rx_data.size() == 0) else begin
          $display("Error at %0t: done high or beats sent during an error run", $time);
          errors = errors + 1;
        end
      end else begin
        while (!busy) @(posedge clk);
        while (busy) @(posedge clk);
        assert (done && !error) else begin
          $display("Error at %0t: done %b error %b at end of run", $time, done, error);
          errors = errors + 1;
        end
        // Hand back every credit before the next start
        while (credits_sent != beats_seen) @(posedge clk);
        @(posedge clk);
        check_stream();
      end
      report_test(t, errs_before);
      p = p + 4 + n_addr;
    end

    $display("Passed %0d, failed %0d", passed, failed);
    if (failed == 0 && errors == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule

// File: mcu_stream_top.f
mcu_pkg.sv
mcu_config_regs.sv
mcu_global_fsm.sv
mcu_data_bram.sv
mcu_bram_reader.sv
mcu_stream_top.sv
tb_mcu_stream_top.sv

// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = tb_mcu_stream_top
FILELIST  = mcu_stream_top.f
LOG       = sim.log

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "ALL TESTS PASSED" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// File: mcu_stream_tests.txt
// Test vectors in hex. First word is the number of tests
// Per test: addr_count inter_count intra_count max_credit_delay, then addr_count memory words
0006
// Single sweep, one beat per word
0004 0001 0001 0000
a001 b002 c003 d004
// Repeated words and repeated sweeps
0003 0002 0003 0002
1111 2222 3333
// Slow credit return
0005 0002 0002 0009
5a00 5a01 5a02 5a03 5a04
// Zero inter count, must fail
0003 0000 0002 0001
dead beef f00d
// Valid run right after the error
0002 0003 0001 0003
0102 0304
// Back-to-back run with new counts and contents
0006 0001 0004 0005
7e01 7e02 7e03 7e04 7e05 7e06
